// ==== hw/rvmini_pkg.sv ====
/* rvmini shared definitions
   Instruction word views, major opcodes and op classes of the RV32 subset */
`default_nettype none

package rvmini_pkg;

  localparam int unsigned XLEN = 32;

  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63
  } opcode_e;

  typedef enum logic [2:0] {
    OpLui,
    OpAddi,
    OpAdd,
    OpSub,
    OpLw,
    OpSw,
    OpBeq,
    OpIllegal
  } op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } insn_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } insn_i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } insn_s_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } insn_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } insn_u_t;

  // One instruction word, seen through each encoding format
  typedef union packed {
    insn_r_t r;
    insn_i_t i;
    insn_s_t s;
    insn_b_t b;
    insn_u_t u;
  } insn_t;

endpackage

`default_nettype wire

// ==== hw/rvmini_decoder.sv ====
/* rvmini instruction decoder
   Classifies an instruction word and extracts register indices and immediate */
`timescale 1ns/1ps
`default_nettype none

module rvmini_decoder #(
  parameter bit RV32E = 1'b0
) (
  input  wire rvmini_pkg::insn_t insn_i,
  output rvmini_pkg::op_e        op_o,
  output logic [4:0]             rd_o,
  output logic [4:0]             rs1_o,
  output logic [4:0]             rs2_o,
  output logic [31:0]            imm_o
);
  import rvmini_pkg::*;

  op_e  op_d;
  logic use_rd;
  logic use_rs1;
  logic use_rs2;
  logic reg_oob;

  // Register fields sit at the same place in every format
  assign rd_o  = insn_i.r.rd;
  assign rs1_o = insn_i.r.rs1;
  assign rs2_o = insn_i.r.rs2;

  always_comb begin
    op_d = OpIllegal;
    case (insn_i.r.opcode)
      OPCODE_LUI: begin
        op_d = OpLui;
      end
      OPCODE_OP_IMM: begin
        if (insn_i.i.funct3 == 3'b000) begin
          op_d = OpAddi;
        end
      end
      OPCODE_OP: begin
        if (insn_i.r.funct3 == 3'b000 && insn_i.r.funct7 == 7'h00) begin
          op_d = OpAdd;
        end else if (insn_i.r.funct3 == 3'b000 && insn_i.r.funct7 == 7'h20) begin
          op_d = OpSub;
        end
      end
      OPCODE_LOAD: begin
        if (insn_i.i.funct3 == 3'b010) begin
          op_d = OpLw;
        end
      end
      OPCODE_STORE: begin
        if (insn_i.s.funct3 == 3'b010) begin
          op_d = OpSw;
        end
      end
      OPCODE_BRANCH: begin
        if (insn_i.b.funct3 == 3'b000) begin
          op_d = OpBeq;
        end
      end
      default: begin
        op_d = OpIllegal;
      end
    endcase
  end

  // Which register fields the class actually reads or writes
  always_comb begin
    use_rd  = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (op_d)
      OpLui: begin
        use_rd = 1'b1;
      end
      OpAddi, OpLw: begin
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
      end
      OpAdd, OpSub: begin
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      OpSw, OpBeq: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      default: begin
        use_rd = 1'b0;
      end
    endcase
  end

  assign reg_oob = RV32E && ((use_rd && rd_o[4]) || (use_rs1 && rs1_o[4]) ||
                             (use_rs2 && rs2_o[4]));
  assign op_o    = reg_oob ? OpIllegal : op_d;

  always_comb begin
    case (op_d)
      OpAddi, OpLw: begin
        imm_o = {{20{insn_i.i.imm[11]}}, insn_i.i.imm};
      end
      OpSw: begin
        imm_o = {{20{insn_i.s.imm_11_5[6]}}, insn_i.s.imm_11_5, insn_i.s.imm_4_0};
      end
      OpBeq: begin
        imm_o = {{19{insn_i.b.imm_12}}, insn_i.b.imm_12, insn_i.b.imm_11,
                 insn_i.b.imm_10_5, insn_i.b.imm_4_1, 1'b0};
      end
      OpLui: begin
        imm_o = {insn_i.u.imm_31_12, 12'h000};
      end
      default: begin
        imm_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rvmini_regfile.sv ====
/* rvmini register file
   Flip-flop registers, two combinational read ports, one write port */
`timescale 1ns/1ps
`default_nettype none

module rvmini_regfile #(
  parameter bit RV32E = 1'b0
) (
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  wire logic [4:0]  raddr_a_i,
  input  wire logic [4:0]  raddr_b_i,
  input  wire logic [4:0]  waddr_i,
  input  wire logic        we_i,
  input  wire logic [31:0] wdata_i,
  output logic [31:0]      rdata_a_o,
  output logic [31:0]      rdata_b_o
);
  import rvmini_pkg::*;

  localparam int NumRegs = RV32E ? 16 : 32;
  localparam int AddrW   = RV32E ? 4 : 5;

  logic [XLEN-1:0] regs_q [NumRegs];

  // x0 is never written, so it keeps its reset value
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i[AddrW-1:0] != '0)) begin
      regs_q[waddr_i[AddrW-1:0]] <= wdata_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i[AddrW-1:0]];
  assign rdata_b_o = regs_q[raddr_b_i[AddrW-1:0]];

endmodule

`default_nettype wire

// ==== hw/rvmini_core.sv ====
/* rvmini core
   Multi-cycle RV32 subset with request/valid memory ports
   and a retirement record per instruction */
`timescale 1ns/1ps
`default_nettype none

module rvmini_core #(
  parameter logic [31:0] BootAddr = 32'h0000_0000,
  parameter bit          RV32E    = 1'b0
) (
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,

  output logic             instr_req_o,
  output logic [31:0]      instr_addr_o,
  input  wire logic        instr_rvalid_i,
  input  wire logic [31:0] instr_rdata_i,

  output logic             data_req_o,
  output logic             data_we_o,
  output logic [31:0]      data_addr_o,
  output logic [31:0]      data_wdata_o,
  input  wire logic        data_rvalid_i,
  input  wire logic [31:0] data_rdata_i,

  output logic             rvfi_valid_o,
  output logic [31:0]      rvfi_insn_o,
  output logic             rvfi_trap_o,
  output logic [31:0]      rvfi_pc_rdata_o,
  output logic [31:0]      rvfi_pc_wdata_o,
  output logic [4:0]       rvfi_rd_addr_o,
  output logic [31:0]      rvfi_rd_wdata_o,
  output logic [31:0]      rvfi_mem_addr_o,
  output logic [31:0]      rvfi_mem_data_o
);
  import rvmini_pkg::*;

  typedef enum logic [2:0] {
    FETCH,
    WAIT_INSN,
    EXEC,
    WAIT_DATA,
    MEM
  } state_e;

  state_e          state_q;
  state_e          state_d;
  logic            req_q;
  logic [XLEN-1:0] pc_q;
  insn_t           insn_q;
  logic [XLEN-1:0] load_q;

  op_e             op;
  logic [4:0]      rd;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;

  logic            is_mem;
  logic            writes_rd;
  logic            retire;
  logic            beq_taken;
  logic [XLEN-1:0] addr_sum;
  logic [XLEN-1:0] pc_next;
  logic [XLEN-1:0] result;

  rvmini_decoder #(
    .RV32E ( RV32E )
  ) u_rvmini_decoder (
    .insn_i ( insn_q ),
    .op_o   ( op     ),
    .rd_o   ( rd     ),
    .rs1_o  ( rs1    ),
    .rs2_o  ( rs2    ),
    .imm_o  ( imm    )
  );

  rvmini_regfile #(
    .RV32E ( RV32E )
  ) u_rvmini_regfile (
    .clk_i,
    .rst_n_i,
    .raddr_a_i ( rs1                 ),
    .raddr_b_i ( rs2                 ),
    .waddr_i   ( rd                  ),
    .we_i      ( retire && writes_rd ),
    .wdata_i   ( result              ),
    .rdata_a_o ( rs1_data            ),
    .rdata_b_o ( rs2_data            )
  );

  assign is_mem    = (op == OpLw) || (op == OpSw);
  assign writes_rd = (op == OpLui) || (op == OpAddi) || (op == OpAdd) ||
                     (op == OpSub) || (op == OpLw);
  assign retire    = ((state_q == EXEC) && !is_mem) || (state_q == MEM);

  // ADDI and the load/store address share one adder
  assign addr_sum  = rs1_data + imm;
  assign beq_taken = (op == OpBeq) && (rs1_data == rs2_data);
  assign pc_next   = beq_taken ? pc_q + imm : pc_q + 32'd4;

  always_comb begin
    case (op)
      OpLui:   result = imm;
      OpAddi:  result = addr_sum;
      OpAdd:   result = rs1_data + rs2_data;
      OpSub:   result = rs1_data - rs2_data;
      OpLw:    result = load_q;
      default: result = '0;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH: begin
        state_d = WAIT_INSN;
      end
      WAIT_INSN: begin
        if (instr_rvalid_i) begin
          state_d = EXEC;
        end
      end
      EXEC: begin
        state_d = is_mem ? WAIT_DATA : WAIT_INSN;
      end
      WAIT_DATA: begin
        if (data_rvalid_i) begin
          state_d = MEM;
        end
      end
      MEM: begin
        state_d = WAIT_INSN;
      end
      default: begin
        state_d = FETCH;
      end
    endcase
  end

  // Next fetch is requested straight out of retirement
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= FETCH;
      req_q   <= 1'b0;
      pc_q    <= BootAddr;
    end else begin
      state_q <= state_d;
      req_q   <= (state_q == FETCH) || retire;
      if (retire) begin
        pc_q <= pc_next;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == WAIT_INSN) && instr_rvalid_i) begin
      insn_q <= instr_rdata_i;
    end
    if ((state_q == WAIT_DATA) && data_rvalid_i) begin
      load_q <= data_rdata_i;
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = pc_q;

  // Address and write data stay stable until the response
  assign data_req_o   = (state_q == EXEC) && is_mem;
  assign data_we_o    = (op == OpSw) && ((state_q == EXEC) || (state_q == WAIT_DATA));
  assign data_addr_o  = addr_sum;
  assign data_wdata_o = rs2_data;

  assign rvfi_valid_o    = retire;
  assign rvfi_insn_o     = insn_q;
  assign rvfi_trap_o     = (op == OpIllegal);
  assign rvfi_pc_rdata_o = pc_q;
  assign rvfi_pc_wdata_o = pc_next;
  assign rvfi_rd_addr_o  = writes_rd ? rd : 5'd0;
  assign rvfi_rd_wdata_o = (rvfi_rd_addr_o != 5'd0) ? result : '0;
  assign rvfi_mem_addr_o = is_mem ? addr_sum : '0;
  assign rvfi_mem_data_o = (op == OpSw) ? rs2_data :
                           (op == OpLw) ? load_q : '0;

endmodule

`default_nettype wire

// ==== hw/rvmini_tracer.sv ====
/* rvmini tracer
   Registers retirement records, numbers them and classifies the instruction */
`timescale 1ns/1ps
`default_nettype none

module rvmini_tracer #(
  parameter bit RV32E = 1'b0
) (
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,

  input  wire logic        rvfi_valid_i,
  input  wire logic [31:0] rvfi_insn_i,
  input  wire logic        rvfi_trap_i,
  input  wire logic [31:0] rvfi_pc_rdata_i,
  input  wire logic [31:0] rvfi_pc_wdata_i,
  input  wire logic [4:0]  rvfi_rd_addr_i,
  input  wire logic [31:0] rvfi_rd_wdata_i,
  input  wire logic [31:0] rvfi_mem_addr_i,
  input  wire logic [31:0] rvfi_mem_data_i,

  output logic             trace_valid_o,
  output logic [63:0]      trace_order_o,
  output rvmini_pkg::op_e  trace_op_o,
  output logic [31:0]      trace_pc_o,
  output logic [31:0]      trace_pc_next_o,
  output logic [31:0]      trace_insn_o,
  output logic             trace_trap_o,
  output logic [4:0]       trace_rd_addr_o,
  output logic [31:0]      trace_rd_wdata_o,
  output logic [31:0]      trace_mem_addr_o,
  output logic [31:0]      trace_mem_data_o
);

  logic [63:0] order_q;

  // Counts records already presented, so it numbers the current one
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      trace_valid_o <= 1'b0;
      order_q       <= '0;
    end else begin
      trace_valid_o <= rvfi_valid_i;
      if (trace_valid_o) begin
        order_q <= order_q + 64'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rvfi_valid_i) begin
      trace_insn_o     <= rvfi_insn_i;
      trace_trap_o     <= rvfi_trap_i;
      trace_pc_o       <= rvfi_pc_rdata_i;
      trace_pc_next_o  <= rvfi_pc_wdata_i;
      trace_rd_addr_o  <= rvfi_rd_addr_i;
      trace_rd_wdata_o <= rvfi_rd_wdata_i;
      trace_mem_addr_o <= rvfi_mem_addr_i;
      trace_mem_data_o <= rvfi_mem_data_i;
    end
  end

  assign trace_order_o = order_q;

  rvmini_decoder #(
    .RV32E ( RV32E )
  ) u_rvmini_decoder (
    .insn_i ( trace_insn_o ),
    .op_o   ( trace_op_o   ),
    .rd_o   (              ),
    .rs1_o  (              ),
    .rs2_o  (              ),
    .imm_o  (              )
  );

endmodule

`default_nettype wire

// ==== hw/rvmini_top_tracing.sv ====
/* rvmini top level with tracing
   Core plus a tracer fed from its retirement record */
`timescale 1ns/1ps
`default_nettype none

module rvmini_top_tracing #(
  parameter logic [31:0] BootAddr = 32'h0000_0000,
  parameter bit          RV32E    = 1'b0
) (
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,

  // Instruction port
  output logic             instr_req_o,
  output logic [31:0]      instr_addr_o,
  input  wire logic        instr_rvalid_i,
  input  wire logic [31:0] instr_rdata_i,

  // Data port
  output logic             data_req_o,
  output logic             data_we_o,
  output logic [31:0]      data_addr_o,
  output logic [31:0]      data_wdata_o,
  input  wire logic        data_rvalid_i,
  input  wire logic [31:0] data_rdata_i,

  // Trace port
  output logic             trace_valid_o,
  output logic [63:0]      trace_order_o,
  output rvmini_pkg::op_e  trace_op_o,
  output logic [31:0]      trace_pc_o,
  output logic [31:0]      trace_pc_next_o,
  output logic [31:0]      trace_insn_o,
  output logic             trace_trap_o,
  output logic [4:0]       trace_rd_addr_o,
  output logic [31:0]      trace_rd_wdata_o,
  output logic [31:0]      trace_mem_addr_o,
  output logic [31:0]      trace_mem_data_o
);

  logic        rvfi_valid;
  logic [31:0] rvfi_insn;
  logic        rvfi_trap;
  logic [31:0] rvfi_pc_rdata;
  logic [31:0] rvfi_pc_wdata;
  logic [4:0]  rvfi_rd_addr;
  logic [31:0] rvfi_rd_wdata;
  logic [31:0] rvfi_mem_addr;
  logic [31:0] rvfi_mem_data;

  rvmini_core #(
    .BootAddr ( BootAddr ),
    .RV32E    ( RV32E    )
  ) u_rvmini_core (
    .clk_i,
    .rst_n_i,

    .instr_req_o,
    .instr_addr_o,
    .instr_rvalid_i,
    .instr_rdata_i,

    .data_req_o,
    .data_we_o,
    .data_addr_o,
    .data_wdata_o,
    .data_rvalid_i,
    .data_rdata_i,

    .rvfi_valid_o    ( rvfi_valid    ),
    .rvfi_insn_o     ( rvfi_insn     ),
    .rvfi_trap_o     ( rvfi_trap     ),
    .rvfi_pc_rdata_o ( rvfi_pc_rdata ),
    .rvfi_pc_wdata_o ( rvfi_pc_wdata ),
    .rvfi_rd_addr_o  ( rvfi_rd_addr  ),
    .rvfi_rd_wdata_o ( rvfi_rd_wdata ),
    .rvfi_mem_addr_o ( rvfi_mem_addr ),
    .rvfi_mem_data_o ( rvfi_mem_data )
  );

  rvmini_tracer #(
    .RV32E ( RV32E )
  ) u_rvmini_tracer (
    .clk_i,
    .rst_n_i,

    .rvfi_valid_i    ( rvfi_valid    ),
    .rvfi_insn_i     ( rvfi_insn     ),
    .rvfi_trap_i     ( rvfi_trap     ),
    .rvfi_pc_rdata_i ( rvfi_pc_rdata ),
    .rvfi_pc_wdata_i ( rvfi_pc_wdata ),
    .rvfi_rd_addr_i  ( rvfi_rd_addr  ),
    .rvfi_rd_wdata_i ( rvfi_rd_wdata ),
    .rvfi_mem_addr_i ( rvfi_mem_addr ),
    .rvfi_mem_data_i ( rvfi_mem_data ),

    .trace_valid_o,
    .trace_order_o,
    .trace_op_o,
    .trace_pc_o,
    .trace_pc_next_o,
    .trace_insn_o,
    .trace_trap_o,
    .trace_rd_addr_o,
    .trace_rd_wdata_o,
    .trace_mem_addr_o,
    .trace_mem_data_o
  );

endmodule

`default_nettype wire

// ==== testbench/tb_rvmini_top_tracing.sv ====
/* Testbench for the rvmini top level with tracing
   Memory model with random latency, a small program and a reference model
   that checks every trace record */
`timescale 1ns/1ps
`default_nettype none

module tb_rvmini_top_tracing;
  import rvmini_pkg::*;

  localparam logic [31:0] BootAddr  = 32'h0000_0100;
  localparam int          NumTraces = 16;
  // About 12 cycles per record at worst, doubled, plus reset
  localparam int          MaxCycles = NumTraces * 12 * 2 + 16;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        instr_rvalid_i = 1'b0;
  logic [31:0] instr_rdata_i  = '0;
  logic        data_rvalid_i  = 1'b0;
  logic [31:0] data_rdata_i   = '0;

  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        data_req_o;
  logic        data_we_o;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;
  logic        trace_valid_o;
  logic [63:0] trace_order_o;
  op_e         trace_op_o;
  logic [31:0] trace_pc_o;
  logic [31:0] trace_pc_next_o;
  logic [31:0] trace_insn_o;
  logic        trace_trap_o;
  logic [4:0]  trace_rd_addr_o;
  logic [31:0] trace_rd_wdata_o;
  logic [31:0] trace_mem_addr_o;
  logic [31:0] trace_mem_data_o;

  // Memory seen by the DUT, and the reference model state
  logic [31:0] mem [256];
  logic [31:0] model_mem [256];
  logic [31:0] model_regs [32];
  logic [31:0] model_pc;
  logic [63:0] model_order;
  logic [31:0] prev_pc_next;
  logic [31:0] fetch_q [$];

  integer      seed = 3;
  int          cycles = 0;
  int          traces = 0;
  int          checks = 0;
  int          errors = 0;
  int          timeouts = 0;
  logic        done = 1'b0;

  int          i_wait = 0;
  int          d_wait = 0;
  logic        i_fire;
  logic        d_fire;
  logic [31:0] i_addr = '0;
  logic [31:0] d_addr = '0;
  logic [31:0] d_wdata = '0;
  logic        d_we = 1'b0;
  logic        mem_req_pending = 1'b0;

  rvmini_top_tracing #(
    .BootAddr ( BootAddr ),
    .RV32E    ( 1'b0     )
  ) i_rvmini_top_tracing (
    .clk_i,
    .rst_n_i,
    .instr_req_o,
    .instr_addr_o,
    .instr_rvalid_i,
    .instr_rdata_i,
    .data_req_o,
    .data_we_o,
    .data_addr_o,
    .data_wdata_o,
    .data_rvalid_i,
    .data_rdata_i,
    .trace_valid_o,
    .trace_order_o,
    .trace_op_o,
    .trace_pc_o,
    .trace_pc_next_o,
    .trace_insn_o,
    .trace_trap_o,
    .trace_rd_addr_o,
    .trace_rd_wdata_o,
    .trace_mem_addr_o,
    .trace_mem_data_o
  );

  always #10 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    checks++;
    assert (act_v === exp_v) else begin
      errors++;
      $display("[FAIL] %s: expected %0h, actual %0h", name, exp_v, act_v);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("ERROR: %s", what);
    end
  endtask

  task automatic load_word(input logic [31:0] addr, input logic [31:0] word);
    mem[addr[9:2]]       = word;
    model_mem[addr[9:2]] = word;
  endtask

  // Op class straight from the RV32I encoding tables
  function automatic op_e classify(input logic [31:0] insn);
    op_e op;
    op = OpIllegal;
    case (insn[6:0])
      7'h37: op = OpLui;
      7'h13: begin
        if (insn[14:12] == 3'b000) begin
          op = OpAddi;
        end
      end
      7'h33: begin
        if (insn[14:12] == 3'b000 && insn[31:25] == 7'h00) begin
          op = OpAdd;
        end else if (insn[14:12] == 3'b000 && insn[31:25] == 7'h20) begin
          op = OpSub;
        end
      end
      7'h03: begin
        if (insn[14:12] == 3'b010) begin
          op = OpLw;
        end
      end
      7'h23: begin
        if (insn[14:12] == 3'b010) begin
          op = OpSw;
        end
      end
      7'h63: begin
        if (insn[14:12] == 3'b000) begin
          op = OpBeq;
        end
      end
      default: op = OpIllegal;
    endcase
    return op;
  endfunction

  task automatic check_trace();
    logic [31:0] insn;
    logic [4:0]  rd;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    op_e         exp_op;
    logic [4:0]  exp_rd;
    logic        exp_trap;
    logic [31:0] exp_next;
    logic [31:0] exp_wdata;
    logic [31:0] exp_maddr;
    logic [31:0] exp_mdata;
    logic [31:0] fetched;
    string       tag;

    insn  = model_mem[model_pc[9:2]];
    rd    = insn[11:7];
    src1  = model_regs[insn[19:15]];
    src2  = model_regs[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};

    exp_op    = classify(insn);
    exp_rd    = 5'd0;
    exp_trap  = 1'b0;
    exp_next  = model_pc + 32'd4;
    exp_wdata = '0;
    exp_maddr = '0;
    exp_mdata = '0;
    case (exp_op)
      OpLui: begin
        exp_rd    = rd;
        exp_wdata = {insn[31:12], 12'h000};
      end
      OpAddi: begin
        exp_rd    = rd;
        exp_wdata = src1 + imm_i;
      end
      OpAdd: begin
        exp_rd    = rd;
        exp_wdata = src1 + src2;
      end
      OpSub: begin
        exp_rd    = rd;
        exp_wdata = src1 - src2;
      end
      OpLw: begin
        exp_rd    = rd;
        exp_maddr = src1 + imm_i;
        exp_mdata = model_mem[exp_maddr[9:2]];
        exp_wdata = exp_mdata;
      end
      OpSw: begin
        exp_maddr = src1 + imm_s;
        exp_mdata = src2;
      end
      OpBeq: begin
        if (src1 == src2) begin
          exp_next = model_pc + imm_b;
        end
      end
      default: exp_trap = 1'b1;
    endcase
    if (exp_rd == 5'd0) begin
      exp_wdata = '0;
    end

    tag = $sformatf("%s@%08h", exp_op.name(), model_pc);
    check_value({tag, " order"}, model_order, trace_order_o);
    check_value({tag, " insn"}, 64'(insn), 64'(trace_insn_o));
    check_value({tag, " op"}, 64'(exp_op), 64'(trace_op_o));
    check_value({tag, " pc"}, 64'(model_pc), 64'(trace_pc_o));
    check_value({tag, " pc_next"}, 64'(exp_next), 64'(trace_pc_next_o));
    check_value({tag, " trap"}, 64'(exp_trap), 64'(trace_trap_o));
    check_value({tag, " rd_addr"}, 64'(exp_rd), 64'(trace_rd_addr_o));
    check_value({tag, " rd_wdata"}, 64'(exp_wdata), 64'(trace_rd_wdata_o));
    check_value({tag, " mem_addr"}, 64'(exp_maddr), 64'(trace_mem_addr_o));
    check_value({tag, " mem_data"}, 64'(exp_mdata), 64'(trace_mem_data_o));
    if (traces > 0) begin
      check_value({tag, " pc after previous"}, 64'(prev_pc_next), 64'(trace_pc_o));
    end

    // Each record must match the address that was fetched for it
    check_true(fetch_q.size() != 0, "trace record without a preceding fetch");
    if (fetch_q.size() != 0) begin
      fetched = fetch_q.pop_front();
      check_value({tag, " fetch addr"}, 64'(model_pc), 64'(fetched));
    end

    if (exp_op == OpLw || exp_op == OpSw) begin
      check_true(mem_req_pending, "memory instruction retired without a data request");
      check_value({tag, " data_we"}, 64'(exp_op == OpSw), 64'(d_we));
      check_value({tag, " data word addr"}, 64'(exp_maddr[31:2]), 64'(d_addr[31:2]));
      if (exp_op == OpSw) begin
        check_value({tag, " data_wdata"}, 64'(exp_mdata), 64'(d_wdata));
      end
      mem_req_pending = 1'b0;
    end

    if (exp_rd != 5'd0) begin
      model_regs[exp_rd] = exp_wdata;
    end
    if (exp_op == OpSw) begin
      model_mem[exp_maddr[9:2]] = exp_mdata;
    end
    model_pc     = exp_next;
    model_order  = model_order + 64'd1;
    prev_pc_next = trace_pc_next_o;
    traces++;
  endtask

  initial begin
    rst_n_i     = 1'b0;
    model_pc    = BootAddr;
    model_order = '0;
    prev_pc_next = BootAddr;
    for (int i = 0; i < 256; i++) begin
      mem[i[7:0]]       = 32'hA5C3_0000 ^ (i * 4);
      model_mem[i[7:0]] = 32'hA5C3_0000 ^ (i * 4);
    end
    for (int i = 0; i < 32; i++) begin
      model_regs[i[4:0]] = '0;
    end

    load_word(BootAddr + 32'h00, 32'h1234_50B7);  // lui  x1, 0x12345
    load_word(BootAddr + 32'h04, 32'hFFB0_0113);  // addi x2, x0, -5
    load_word(BootAddr + 32'h08, 32'h0020_81B3);  // add  x3, x1, x2
    load_word(BootAddr + 32'h0C, 32'h4020_8233);  // sub  x4, x1, x2
    load_word(BootAddr + 32'h10, 32'h0070_8013);  // addi x0, x1, 7
    load_word(BootAddr + 32'h14, 32'h2000_0293);  // addi x5, x0, 0x200
    load_word(BootAddr + 32'h18, 32'h0032_A423);  // sw   x3, 8(x5)
    load_word(BootAddr + 32'h1C, 32'h0082_A303);  // lw   x6, 8(x5)
    load_word(BootAddr + 32'h20, 32'h0043_0463);  // beq  x6, x4, +8 not taken
    load_word(BootAddr + 32'h24, 32'h0033_0663);  // beq  x6, x3, +12 taken
    load_word(BootAddr + 32'h28, 32'h0010_0393);  // addi x7, x0, 1 skipped
    load_word(BootAddr + 32'h2C, 32'h0020_0393);  // addi x7, x0, 2 skipped
    load_word(BootAddr + 32'h30, 32'hFFFF_F0FF);  // illegal opcode with rd field x1
    load_word(BootAddr + 32'h34, 32'h0003_03B3);  // add  x7, x6, x0
    load_word(BootAddr + 32'h38, 32'h0000_8433);  // add  x8, x1, x0
    load_word(BootAddr + 32'h3C, 32'h0000_0063);  // beq  x0, x0, 0

    repeat (3) @(posedge clk_i);
    #2 rst_n_i = 1'b1;
  end

  // Memory model and trace checks on each rising edge
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    i_fire = 1'b0;
    d_fire = 1'b0;
    if (!rst_n_i) begin
      if (cycles > 1) begin
        check_true(!instr_req_o && !data_req_o && !trace_valid_o,
                   "request or trace valid high during reset");
      end
    end else begin
      if (trace_valid_o) begin
        check_trace();
        if (traces == NumTraces) begin
          done = 1'b1;
        end
      end
      if (instr_req_o) begin
        fetch_q.push_back(instr_addr_o);
        i_addr = instr_addr_o;
        i_wait = 1 + ({$random(seed)} % 3);
      end
      if (data_req_o) begin
        d_we            = data_we_o;
        d_addr          = data_addr_o;
        d_wdata         = data_wdata_o;
        mem_req_pending = 1'b1;
        if (data_we_o) begin
          mem[data_addr_o[9:2]] = data_wdata_o;
        end
        d_wait = 1 + ({$random(seed)} % 3);
      end
      if (i_wait > 0) begin
        i_wait = i_wait - 1;
        i_fire = (i_wait == 0);
      end
      if (d_wait > 0) begin
        d_wait = d_wait - 1;
        d_fire = (d_wait == 0);
      end
    end
    #2;
    instr_rvalid_i = i_fire;
    instr_rdata_i  = i_fire ? mem[i_addr[9:2]] : '0;
    data_rvalid_i  = d_fire;
    data_rdata_i   = (d_fire && !d_we) ? mem[d_addr[9:2]] : '0;
  end

  initial begin
    while (!done && cycles < MaxCycles) begin
      @(negedge clk_i);
    end
    if (!done) begin
      timeouts++;
      $display("ERROR: trace stalled, %0d of %0d records seen after %0d cycles",
               traces, NumTraces, cycles);
    end
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
hw/rvmini_pkg.sv
hw/rvmini_decoder.sv
hw/rvmini_regfile.sv
hw/rvmini_core.sv
hw/rvmini_tracer.sv
hw/rvmini_top_tracing.sv
testbench/tb_rvmini_top_tracing.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_rvmini_top_tracing -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^Simulation PASSED$"; then
  exit 0
fi
exit 1
